/* Makefile */
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG) || [ $$rc -ne 0 ]; then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+source
source/ifu_pkg.sv
source/fetch_if.sv
source/pc_gen.sv
source/cache_array.sv
source/icache.sv
source/instr_queue.sv
source/ifu_top.sv
testbench/axi_mem_model.sv
testbench/tb_ifu.sv

/* source/cache_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache tag, data and valid storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "ifu_defs.svh"

module cache_array (
	input  logic                                 CLK,
	input  logic                                 arst_n,
	input  logic [$clog2(`IFU_SETS)-1:0]         set,
	input  logic [$clog2(`IFU_BEATS)-1:0]        beat,
	input  logic [`IFU_WAYS-1:0]                 tag_wen,
	input  logic [`IFU_TAG_W-1:0]                tag_wdata,
	input  logic [`IFU_WAYS-1:0]                 data_wen,
	input  logic [63:0]                          data_wdata,
	input  logic                                 rd_en,
	output logic [`IFU_WAYS-1:0][`IFU_TAG_W-1:0] tag_rdata,
	output logic [`IFU_WAYS-1:0][63:0]           data_rdata,
	output logic [`IFU_WAYS-1:0]                 valid_rdata,
	input  logic                                 valid_clear
);

	localparam int WAYS  = `IFU_WAYS;
	localparam int SETS  = `IFU_SETS;
	localparam int BEATS = `IFU_BEATS;

	logic [`IFU_TAG_W-1:0] tag_mem [WAYS][SETS];
	logic [63:0]           data_mem [WAYS][SETS][BEATS];
	// One bit per way and set
	logic [WAYS-1:0][SETS-1:0] valid_bits;

	// Per-way write strobes
	always_ff @(posedge CLK) begin
		for (int w = 0; w < WAYS; w++) begin
			if (tag_wen[w]) begin
				tag_mem[w][set] <= tag_wdata;
			end
			if (data_wen[w]) begin
				data_mem[w][set][beat] <= data_wdata;
			end
		end
	end

	// Tag write marks the line, fence wipes everything at once
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
		end else if (valid_clear) begin
			valid_bits <= '0;
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (tag_wen[w]) begin
					valid_bits[w][set] <= 1'b1;
				end
			end
		end
	end

	// Registered read of all ways together
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			for (int w = 0; w < WAYS; w++) begin
				tag_rdata[w]   <= tag_mem[w][set];
				data_rdata[w]  <= data_mem[w][set][beat];
				valid_rdata[w] <= valid_bits[w][set];
			end
		end
	end

	// Victim select in the cache must stay one-hot
	a_one_way_write: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot0(tag_wen | data_wen));

endmodule

`default_nettype wire

/* source/fetch_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache to queue fetch word channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface fetch_if;

	// Address of the word, 8-byte aligned
	logic [63:0]         pc;
	ifu_pkg::fetch_word_t word;
	// Valid/ready pair, payload held while valid waits
	logic                valid;
	logic                ready;

	// Cache side
	modport producer (output pc, output word, output valid, input ready);

	// Queue side
	modport consumer (input pc, input word, input valid, output ready);

endinterface

`default_nettype wire

/* source/icache.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache control: tag check, refill, fence, LFSR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "ifu_defs.svh"

module icache (
	input  logic        CLK,
	input  logic        arst_n,
	input  logic [63:0] addr,
	input  logic        valid,
	output logic        ready,
	input  logic        flush,
	input  logic        fence,
	output logic        fence_done,
	output logic [31:0] araddr,
	output logic [7:0]  arlen,
	output logic        arvalid,
	input  logic        arready,
	input  logic [63:0] rdata,
	input  logic        rlast,
	input  logic        rvalid,
	output logic        rready,
	fetch_if.producer   fetch
);

	localparam int WAYS   = `IFU_WAYS;
	localparam int TAG_W  = `IFU_TAG_W;
	localparam int OFF_W  = $clog2(`IFU_LINE_BYTES);
	localparam int SET_W  = $clog2(`IFU_SETS);
	localparam int BEAT_W = $clog2(`IFU_BEATS);
	localparam int WAY_W  = $clog2(WAYS);

	ifu_pkg::ic_state_t state, state_nxt;

	logic [63:0]                addr_q;
	logic [TAG_W-1:0]           tag_q;
	logic [SET_W-1:0]           set_sel;
	logic [BEAT_W-1:0]          beat_sel;
	logic [BEAT_W-1:0]          beat_cnt;
	logic [WAYS-1:0][TAG_W-1:0] tag_rdata;
	logic [WAYS-1:0][63:0]      data_rdata;
	logic [WAYS-1:0]            valid_rdata;
	logic [WAYS-1:0]            hit;
	logic [WAYS-1:0]            victim;
	logic [WAYS-1:0]            victim_q;
	logic [63:0]                hit_data;
	logic [15:0]                lfsr;
	logic                       fence_pend;
	logic                       fence_req;
	logic                       kill;
	logic                       take;
	logic                       beat_fire;
	logic                       start_miss;
	logic                       hit_load;
	logic                       fwd_load;
	logic                       out_valid;
	logic [63:0]                out_pc;
	ifu_pkg::fetch_word_t       out_word;

	// Only address bits [31:0] take part in the lookup
	assign tag_q = addr_q[OFF_W+SET_W +: TAG_W];

	assign fence_req = fence | fence_pend;
	// New lookup only when the output slot is free by the CHECK cycle
	assign ready = (state == ifu_pkg::IDLE) & ~fence_req & (~out_valid | fetch.ready);
	assign take  = valid & ready;

	// Hit check against the registered read of both ways
	always_comb begin
		hit_data = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit[w] = valid_rdata[w] & (tag_rdata[w] == tag_q);
			if (hit[w]) begin
				hit_data = data_rdata[w];
			end
		end
	end

	// Victim: lowest invalid way, otherwise a random one
	always_comb begin
		victim = '0;
		victim[lfsr[WAY_W-1:0]] = 1'b1;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid_rdata[w]) begin
				victim = '0;
				victim[w] = 1'b1;
			end
		end
	end

	assign hit_load   = (state == ifu_pkg::CHECK) & (|hit) & ~flush;
	assign start_miss = (state == ifu_pkg::CHECK) & ~(|hit) & ~flush;
	assign beat_fire  = (state == ifu_pkg::MISS) & rvalid & rready;
	// Requested beat goes straight out unless a redirect killed it
	assign fwd_load = beat_fire & (beat_cnt == addr_q[OFF_W-1 -: BEAT_W]) & ~kill & ~flush;

	always_comb begin
		state_nxt = state;
		case (state)
			ifu_pkg::IDLE: begin
				if (fence_req) begin
					state_nxt = ifu_pkg::FENCE;
				end else if (take) begin
					state_nxt = ifu_pkg::CHECK;
				end
			end
			ifu_pkg::CHECK: begin
				if (start_miss) begin
					state_nxt = ifu_pkg::MISS;
				end else begin
					state_nxt = ifu_pkg::IDLE;
				end
			end
			// Line always runs to its last beat
			ifu_pkg::MISS: begin
				if (beat_fire && rlast) begin
					state_nxt = ifu_pkg::IDLE;
				end
			end
			default: state_nxt = ifu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ifu_pkg::IDLE;
			fence_pend <= 1'b0;
			fence_done <= 1'b0;
			kill       <= 1'b0;
			arvalid    <= 1'b0;
			beat_cnt   <= '0;
			out_valid  <= 1'b0;
			lfsr       <= 16'hace1;
		end else begin
			state <= state_nxt;
			// Fence seen while busy waits for IDLE
			fence_pend <= (state != ifu_pkg::FENCE) & (fence_pend | fence);
			// Pulse once the clear has landed
			fence_done <= (state == ifu_pkg::FENCE);
			kill <= (state_nxt == ifu_pkg::MISS) & (kill | (flush & (state == ifu_pkg::MISS)));
			if (start_miss) begin
				arvalid <= 1'b1;
			end else if (arready) begin
				arvalid <= 1'b0;
			end
			if (start_miss) begin
				beat_cnt <= '0;
			end else if (beat_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			if (flush) begin
				out_valid <= 1'b0;
			end else if (hit_load || fwd_load) begin
				out_valid <= 1'b1;
			end else if (fetch.ready) begin
				out_valid <= 1'b0;
			end
			// Taps 16,14,13,11
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			addr_q <= addr;
		end
		if (start_miss) begin
			victim_q <= victim;
		end
		if (hit_load || fwd_load) begin
			out_pc       <= addr_q;
			out_word.raw <= hit_load ? hit_data : rdata;
		end
	end

	// Array index: lookup address in IDLE, held address otherwise
	assign set_sel  = (state == ifu_pkg::IDLE) ? addr[OFF_W +: SET_W] : addr_q[OFF_W +: SET_W];
	assign beat_sel = (state == ifu_pkg::MISS) ? beat_cnt : addr[OFF_W-1 -: BEAT_W];

	cache_array array0 (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.set         (set_sel),
		.beat        (beat_sel),
		.tag_wen     (victim & {WAYS{start_miss}}),
		.tag_wdata   (tag_q),
		.data_wen    (victim_q & {WAYS{beat_fire}}),
		.data_wdata  (rdata),
		.rd_en       (take),
		.tag_rdata   (tag_rdata),
		.data_rdata  (data_rdata),
		.valid_rdata (valid_rdata),
		.valid_clear (state == ifu_pkg::FENCE)
	);

	// Read burst, whole line from its first byte
	assign araddr = {addr_q[31:OFF_W], OFF_W'(0)};
	assign arlen  = 8'(`IFU_BEATS - 1);
	assign rready = (state == ifu_pkg::MISS);

	assign fetch.valid = out_valid;
	assign fetch.pc    = out_pc;
	assign fetch.word  = out_word;

	a_arvalid_hold: assert property (@(posedge CLK) disable iff (!arst_n)
		arvalid && !arready |=> arvalid);

	a_araddr_align: assert property (@(posedge CLK) disable iff (!arst_n)
		arvalid |-> araddr[OFF_W-1:0] == '0);

	// Leaving MISS needs rlast on the final beat of the line
	a_miss_until_last: assert property (@(posedge CLK) disable iff (!arst_n)
		state == ifu_pkg::MISS && state_nxt != ifu_pkg::MISS
		|-> rlast && beat_cnt == BEAT_W'(`IFU_BEATS - 1));

endmodule

`default_nettype wire

/* source/ifu_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit geometry: cache ways, sets, line size, burst
// length, tag width and instruction queue depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// Instruction cache organisation
`define IFU_WAYS        2
`define IFU_SETS        64
`define IFU_LINE_BYTES  32
// 64-bit beats per line refill
`define IFU_BEATS       4
// Address bits [31:11]
`define IFU_TAG_W       21

// Fetch words held between cache and consumer
`define IFU_QUEUE_DEPTH 4

`endif

/* source/ifu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch word union and cache state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ifu_pkg;

	// Two instructions per fetch word
	// Lower address sits in the low half, handed out first
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} fetch_slots_t;

	// Same 64 bits seen as bus beat or as instruction pair
	typedef union packed {
		logic [63:0]  raw;
		fetch_slots_t slot;
	} fetch_word_t;

	// Cache control states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		CHECK = 2'd1,
		MISS  = 2'd2,
		FENCE = 2'd3
	} ic_state_t;

endpackage

`default_nettype wire

/* source/ifu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit top: PC stage, cache and instruction queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ifu_top (
	input  logic        CLK,
	input  logic        arst_n,
	input  logic        redirect_valid,
	input  logic [63:0] redirect_pc,
	input  logic        fence,
	output logic        fence_done,
	output logic [31:0] araddr,
	output logic [7:0]  arlen,
	output logic        arvalid,
	input  logic        arready,
	input  logic [63:0] rdata,
	input  logic        rlast,
	input  logic        rvalid,
	output logic        rready,
	output logic        instr_valid,
	output logic [63:0] instr_pc,
	output logic [31:0] instr,
	input  logic        instr_ready
);

	logic [63:0] pc_addr;
	logic        pc_valid;
	logic        pc_ready;

	// Cache to queue words
	fetch_if fetch_bus ();

	pc_gen pc_gen0 (
		.CLK            (CLK),
		.arst_n         (arst_n),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.addr           (pc_addr),
		.valid          (pc_valid),
		.ready          (pc_ready)
	);

	// Redirect doubles as flush for everything past the PC
	icache icache0 (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.addr       (pc_addr),
		.valid      (pc_valid),
		.ready      (pc_ready),
		.flush      (redirect_valid),
		.fence      (fence),
		.fence_done (fence_done),
		.araddr     (araddr),
		.arlen      (arlen),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rlast      (rlast),
		.rvalid     (rvalid),
		.rready     (rready),
		.fetch      (fetch_bus)
	);

	instr_queue queue0 (
		.CLK         (CLK),
		.arst_n      (arst_n),
		.flush       (redirect_valid),
		.fetch       (fetch_bus),
		.instr_valid (instr_valid),
		.instr_pc    (instr_pc),
		.instr       (instr),
		.instr_ready (instr_ready)
	);

endmodule

`default_nettype wire

/* source/instr_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch word queue, splits words into instructions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "ifu_defs.svh"

module instr_queue (
	input  logic        CLK,
	input  logic        arst_n,
	input  logic        flush,
	fetch_if.consumer   fetch,
	output logic        instr_valid,
	output logic [63:0] instr_pc,
	output logic [31:0] instr,
	input  logic        instr_ready
);

	localparam int DEPTH = `IFU_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [63:0]          pc_mem [DEPTH];
	ifu_pkg::fetch_word_t word_mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [PTR_W:0]       count;
	// Low when the lo slot of the head is on offer
	logic                 half;
	logic                 wr_fire;
	logic                 pop_word;
	ifu_pkg::fetch_word_t head;

	assign fetch.ready = (count != (PTR_W + 1)'(DEPTH));
	assign wr_fire     = fetch.valid & fetch.ready & ~flush;

	assign head        = word_mem[rd_ptr];
	// Nothing leaves in a redirect cycle
	assign instr_valid = (count != '0) & ~flush;
	assign instr       = half ? head.slot.hi : head.slot.lo;
	assign instr_pc    = half ? pc_mem[rd_ptr] + 64'd4 : pc_mem[rd_ptr];
	// Head word retires with its second instruction
	assign pop_word    = instr_valid & instr_ready & half;

	always_ff @(posedge CLK) begin
		if (wr_fire) begin
			pc_mem[wr_ptr]   <= fetch.pc;
			word_mem[wr_ptr] <= fetch.word;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			half   <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			half   <= 1'b0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (instr_valid && instr_ready) begin
				half <= ~half;
			end
			if (pop_word) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(wr_fire) - (PTR_W + 1)'(pop_word);
		end
	end

	// Full and not draining means nothing gets in
	a_no_write_full: assert property (@(posedge CLK) disable iff (!arst_n)
		count == (PTR_W + 1)'(DEPTH) && !flush && !pop_word |=> count == (PTR_W + 1)'(DEPTH));

endmodule

`default_nettype wire

/* source/pc_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter stage, sequential advance and redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pc_gen (
	input  logic        CLK,
	input  logic        arst_n,
	input  logic        redirect_valid,
	input  logic [63:0] redirect_pc,
	output logic [63:0] addr,
	output logic        valid,
	input  logic        ready
);

	localparam logic [63:0] BOOT_ADDR = 64'h0000_1000;
	// One fetch word per step
	localparam logic [63:0] STEP = 64'd8;

	logic run;

	// Goes high one cycle after reset and stays there
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	// No request during a redirect cycle
	// Cache flushes in that same cycle
	assign valid = run & ~redirect_valid;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			addr <= BOOT_ADDR;
		end else if (redirect_valid) begin
			// Target forced onto a word boundary
			addr <= {redirect_pc[63:3], 3'b000};
		end else if (valid && ready) begin
			addr <= addr + STEP;
		end
	end

endmodule

`default_nettype wire

/* testbench/axi_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-burst memory model with random stalls, AR counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module axi_mem_model (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] araddr,
	input  logic [7:0]  arlen,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic        rlast,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] ar_count
);

	logic        ar_seen;
	logic        r_seen;
	logic [31:0] ar_addr_q;
	logic [7:0]  last_beat;
	logic [7:0]  beat;
	logic        busy;
	int unsigned wait_cnt;

	// Each 32-bit half holds its own byte address xor a fixed pattern
	function automatic logic [63:0] word_at(input logic [31:0] a);
		ifu_pkg::fetch_word_t w;
		w.slot.lo = a ^ 32'h5a5a_0000;
		w.slot.hi = (a + 32'd4) ^ 32'h5a5a_0000;
		return w.raw;
	endfunction

	// Handshakes as seen on the rising edge
	always @(posedge clk) begin
		ar_seen <= arvalid & arready;
		r_seen  <= rvalid & rready;
		if (arvalid && arready) begin
			ar_addr_q <= araddr;
			last_beat <= arlen;
		end
	end

	// Outputs change on the falling edge only
	always @(negedge clk or negedge arst_n) begin : drive
		int unsigned gap;
		if (!arst_n) begin
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			rlast    <= 1'b0;
			rdata    <= '0;
			busy     <= 1'b0;
			beat     <= '0;
			wait_cnt <= 0;
			ar_count <= '0;
		end else if (!busy) begin
			if (ar_seen) begin
				// Request taken, first beat after 0 to 2 idle cycles
				arready  <= 1'b0;
				busy     <= 1'b1;
				beat     <= '0;
				ar_count <= ar_count + 32'd1;
				wait_cnt <= $urandom % 3;
			end else if (arvalid && !arready) begin
				if (wait_cnt == 0) begin
					arready <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end else if (!arvalid) begin
				// arready delay for the next request, 0 to 3 cycles
				wait_cnt <= $urandom % 4;
			end
		end else if (r_seen) begin
			if (beat == last_beat) begin
				rvalid   <= 1'b0;
				rlast    <= 1'b0;
				busy     <= 1'b0;
				wait_cnt <= $urandom % 4;
			end else begin
				gap = $urandom % 3;
				beat <= beat + 8'd1;
				if (gap == 0) begin
					// Back to back, rvalid stays up
					rdata <= word_at(ar_addr_q + 32'(beat + 8'd1) * 32'd8);
					rlast <= (beat + 8'd1 == last_beat);
				end else begin
					rvalid   <= 1'b0;
					wait_cnt <= gap - 1;
				end
			end
		end else if (!rvalid) begin
			if (wait_cnt == 0) begin
				rvalid <= 1'b1;
				rdata  <= word_at(ar_addr_q + 32'(beat) * 32'd8);
				rlast  <= (beat == last_beat);
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_ifu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch unit testbench: clock, reset, directed tests, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_ifu;

	// Cycles any single wait may take
	localparam int TIMEOUT = 2000;
	// Idle bus cycles that count as a settled pipeline
	localparam int QUIET = 20;

	logic        clk;
	logic        arst_n;
	logic        redirect_valid;
	logic [63:0] redirect_pc;
	logic        fence;
	logic        fence_done;
	logic [31:0] araddr;
	logic [7:0]  arlen;
	logic        arvalid;
	logic        arready;
	logic [63:0] rdata;
	logic        rlast;
	logic        rvalid;
	logic        rready;
	logic        instr_valid;
	logic [63:0] instr_pc;
	logic [31:0] instr;
	logic        instr_ready;
	logic [31:0] ar_count;

	int errors = 0;
	int checks = 0;
	bit aborted = 1'b0;

	ifu_top dut0 (
		.CLK(clk), .arst_n(arst_n),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.fence(fence), .fence_done(fence_done),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.instr_valid(instr_valid), .instr_pc(instr_pc), .instr(instr),
		.instr_ready(instr_ready)
	);

	axi_mem_model mem0 (
		.clk(clk), .arst_n(arst_n),
		.araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.ar_count(ar_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Memory rule seen from the consumer side
	function automatic logic [31:0] expected_instr(input logic [63:0] pc);
		return pc[31:0] ^ 32'h5a5a_0000;
	endfunction

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Every read request asks for one whole line of four beats
	always @(negedge clk) begin
		if (arst_n && arvalid) begin
			check("read request arlen", 64'd3, 64'(arlen));
			check("read request araddr offset", 64'd0, 64'(araddr[4:0]));
		end
	end

	// Stops the remaining tests, the run then ends through the summary
	task automatic report_timeout(input string what);
		errors++;
		aborted = 1'b1;
		$display("Timeout: gave up waiting for %s", what);
	endtask

	task automatic report_test(input string name, input int err0);
		$display("Test %s finished with %0d errors", name, errors - err0);
	endtask

	// One consumer handshake, optionally with random back-pressure
	task automatic get_instr(input bit stall, output logic [63:0] pc,
			output logic [31:0] word);
		bit got;
		got  = 1'b0;
		pc   = '0;
		word = '0;
		for (int n = 0; n < TIMEOUT && !got; n++) begin
			@(negedge clk);
			instr_ready = (stall && ($urandom % 2 == 0)) ? 1'b0 : 1'b1;
			// Taken on the coming rising edge
			if (instr_ready && instr_valid) begin
				pc   = instr_pc;
				word = instr;
				got  = 1'b1;
			end
		end
		if (!got) begin
			report_timeout("an instruction");
		end
	endtask

	// Gap-free stream from start, each value by the memory rule
	task automatic fetch_and_compare(input string name, input logic [63:0] start,
			input int count, input bit stall);
		logic [63:0] pc;
		logic [31:0] word;
		logic [63:0] exp_pc;
		for (int i = 0; i < count && !aborted; i++) begin
			exp_pc = start + 64'(4 * i);
			get_instr(stall, pc, word);
			if (!aborted) begin
				check({name, " pc"}, exp_pc, pc);
				check({name, " instr"}, 64'(expected_instr(exp_pc)), 64'(word));
			end
		end
		@(negedge clk);
		instr_ready = 1'b0;
	endtask

	// Single-cycle redirect
	task automatic redirect(input logic [63:0] target);
		@(negedge clk);
		redirect_valid = 1'b1;
		redirect_pc    = target;
		@(negedge clk);
		redirect_valid = 1'b0;
	endtask

	// Queue full and no refill running for QUIET cycles
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		for (int n = 0; n < TIMEOUT && quiet < QUIET; n++) begin
			@(negedge clk);
			if (arvalid || rready) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		if (quiet < QUIET) begin
			report_timeout("the refill traffic to stop");
		end
	endtask

	// Select 0 waits for a refill in progress, 1 for fence_done
	task automatic wait_high(input string what, input int sel);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < TIMEOUT && !seen; n++) begin
			@(negedge clk);
			seen = (sel == 0) ? rready : fence_done;
		end
		if (!seen) begin
			report_timeout(what);
		end
	endtask

	task automatic test_sequential();
		int err0;
		err0 = errors;
		fetch_and_compare("sequential", 64'h1000, 24, 1'b0);
		wait_quiet();
		report_test("sequential", err0);
	endtask

	// Same range again, all lines already resident
	task automatic test_hits();
		int          err0;
		logic [31:0] ar0;
		err0 = errors;
		ar0  = ar_count;
		redirect(64'h1000);
		fetch_and_compare("hits", 64'h1000, 24, 1'b0);
		wait_quiet();
		check("hits ar_count", 64'(ar0), 64'(ar_count));
		report_test("hits", err0);
	endtask

	task automatic test_redirect_refill();
		int err0;
		err0 = errors;
		redirect(64'h4000);
		wait_high("a refill to start", 0);
		// Lands while the 0x4000 line is still on the bus
		redirect(64'h8000);
		fetch_and_compare("redirect_refill", 64'h8000, 24, 1'b0);
		report_test("redirect_refill", err0);
	endtask

	task automatic test_fence();
		int          err0;
		logic [31:0] ar0;
		err0 = errors;
		wait_quiet();
		ar0 = ar_count;
		@(negedge clk);
		fence = 1'b1;
		@(negedge clk);
		fence = 1'b0;
		wait_high("fence_done", 1);
		redirect(64'h1000);
		fetch_and_compare("fence", 64'h1000, 8, 1'b0);
		wait_quiet();
		check("fence ar_count grew", 64'd1, 64'(ar_count > ar0));
		report_test("fence", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		err0 = errors;
		redirect(64'h1000);
		fetch_and_compare("backpressure", 64'h1000, 40, 1'b1);
		report_test("backpressure", err0);
	endtask

	// Three lines in set 0 compete for two ways
	task automatic test_replacement();
		int          err0;
		logic [31:0] ar0;
		logic [63:0] lines [3];
		err0     = errors;
		lines[0] = 64'h1000;
		lines[1] = 64'h1800;
		lines[2] = 64'h2000;
		for (int i = 0; i < 3; i++) begin
			redirect(lines[i]);
			fetch_and_compare("replacement fill", lines[i], 8, 1'b0);
		end
		wait_quiet();
		ar0 = ar_count;
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 3; i++) begin
				redirect(lines[i]);
				fetch_and_compare("replacement loop", lines[i], 8, 1'b0);
			end
		end
		wait_quiet();
		check("replacement ar_count grew", 64'd1, 64'(ar_count > ar0));
		report_test("replacement", err0);
	endtask

	initial begin
		void'($urandom(32'h0280_b728));
		arst_n         = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		fence          = 1'b0;
		instr_ready    = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		// Outputs idle while reset is held
		check("reset arvalid", 64'd0, 64'(arvalid));
		check("reset rready", 64'd0, 64'(rready));
		check("reset instr_valid", 64'd0, 64'(instr_valid));
		check("reset fence_done", 64'd0, 64'(fence_done));
		arst_n = 1'b1;

		test_sequential();
		if (!aborted) begin
			test_hits();
		end
		if (!aborted) begin
			test_redirect_refill();
		end
		if (!aborted) begin
			test_fence();
		end
		if (!aborted) begin
			test_backpressure();
		end
		if (!aborted) begin
			test_replacement();
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
